// File: cpuPkg.sv
package cpuPkg;

    localparam int dataWidth   = 32;
    localparam int memAddrBits = 10;
    localparam int memWords    = 1 << memAddrBits;

    typedef enum logic [2:0] {
        loadNone,
        loadByteS,
        loadByteU,
        loadHalfS,
        loadHalfU,
        loadWord
    } loadType;

    typedef enum logic [1:0] {
        storeNone,
        storeByte,
        storeHalf,
        storeWord
    } storeType;

    // everything the MEM stage needs from EXE, about 140 bits.
    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] aluOut;    // effective address for loads and stores.
        logic [dataWidth-1:0] storeData;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] instr;
        loadType              loadKind;
        storeType             storeKind;
        logic [4:0]           dst;
        logic                 regsWr;
    } exeMemBundle;

    typedef struct packed {
        logic                   req;
        logic [memAddrBits-1:0] wordAddr;
        logic [3:0]             byteEn;    // all zero means a plain read.
        logic [dataWidth-1:0]   writeData;
    } memReq;

    typedef struct packed {
        logic                 rvalid;
        logic [dataWidth-1:0] readData;
    } memResp;

endpackage

// File: exeMemReg.sv
`timescale 1ns/1ps

module exeMemReg (
    input  logic                clk,
    input  logic                rstN,
    input  logic                memWr,
    input  logic                memFlush,
    input  cpuPkg::exeMemBundle exeIn,
    output cpuPkg::exeMemBundle stageOut,
    output logic                dcacheFlush
);

    typedef enum logic {
        flushNormal,
        flushCache
    } flushState;

    flushState state;
    flushState stateNext;

    // a held flush only starts one cache flush, the state must pass through normal first.
    always_comb begin
        if (state == flushNormal && memFlush) begin
            stateNext = flushCache;
        end else begin
            stateNext = flushNormal;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= flushNormal;
        end else begin
            state <= stateNext;
        end
    end

    assign dcacheFlush = (state == flushCache);

    always_ff @(posedge clk) begin
        if (!rstN || memFlush) begin
            stageOut <= '0;              // a flushed stage holds an invalid bubble.
        end else if (memWr) begin
            stageOut <= exeIn;
        end
    end

    // the cache flush is a single pulse, never a level.
    pulseOnly: assert property (@(posedge clk) disable iff (!rstN)
        dcacheFlush |=> !dcacheFlush)
        else $error("dcacheFlush held for more than one cycle.");

endmodule

// File: loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::exeMemBundle stageIn,
    output cpuPkg::memReq       dataReq,
    input  cpuPkg::memResp      dataResp,
    output logic                stall,
    output logic                wbValid,
    output logic [31:0]         wbData,
    output logic [4:0]          wbDst,
    output logic                memExcept
);
    import cpuPkg::*;

    logic        isLoad;
    logic        isStore;
    logic        misaligned;
    logic        accessOk;
    logic        respPending;
    logic [1:0]  offset;
    logic [1:0]  pendOffset;
    loadType     pendKind;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    logic [31:0] loadData;

    assign offset  = stageIn.aluOut[1:0];
    assign isLoad  = stageIn.valid && (stageIn.loadKind != loadNone);
    assign isStore = stageIn.valid && (stageIn.storeKind != storeNone);

    always_comb begin
        misaligned = 1'b0;
        if (stageIn.loadKind inside {loadHalfS, loadHalfU} || stageIn.storeKind == storeHalf) begin
            misaligned = offset[0];
        end
        if (stageIn.loadKind == loadWord || stageIn.storeKind == storeWord) begin
            misaligned = |offset;
        end
    end

    // in the response cycle the bundle is still in the stage and must not ask again.
    assign accessOk  = (isLoad || isStore) && !misaligned && !respPending;
    assign memExcept = (isLoad || isStore) && misaligned && !respPending;
    assign stall     = accessOk;

    always_comb begin
        dataReq.req       = accessOk;
        dataReq.wordAddr  = stageIn.aluOut[memAddrBits+1:2];
        dataReq.byteEn    = 4'b0000;
        dataReq.writeData = stageIn.storeData;
        if (isStore) begin
            case (stageIn.storeKind)
                storeByte: begin
                    dataReq.byteEn    = 4'b0001 << offset;
                    dataReq.writeData = {4{stageIn.storeData[7:0]}};
                end
                storeHalf: begin
                    dataReq.byteEn    = offset[1] ? 4'b1100 : 4'b0011;
                    dataReq.writeData = {2{stageIn.storeData[15:0]}};
                end
                storeWord: begin
                    dataReq.byteEn = 4'b1111;
                end
                default: begin
                    dataReq.byteEn = 4'b0000;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            respPending <= 1'b0;
        end else begin
            respPending <= accessOk;
        end
    end

    always_ff @(posedge clk) begin
        if (accessOk) begin
            pendOffset <= offset;
            pendKind   <= stageIn.loadKind;
        end
    end

    always_comb begin
        loadByte = dataResp.readData[{pendOffset, 3'b000} +: 8];
        loadHalf = pendOffset[1] ? dataResp.readData[31:16] : dataResp.readData[15:0];
        case (pendKind)
            loadByteS: loadData = {{24{loadByte[7]}}, loadByte};
            loadByteU: loadData = {24'b0, loadByte};
            loadHalfS: loadData = {{16{loadHalf[15]}}, loadHalf};
            loadHalfU: loadData = {16'b0, loadHalf};
            default:   loadData = dataResp.readData;
        endcase
    end

    // a bundle flushed while waiting reads back invalid and so never retires.
    always_comb begin
        if (respPending) begin
            wbValid = dataResp.rvalid && stageIn.valid && stageIn.regsWr;
        end else begin
            wbValid = stageIn.valid && !isLoad && !isStore && stageIn.regsWr;
        end
    end

    assign wbData = respPending ? loadData : stageIn.aluOut;
    assign wbDst  = stageIn.dst;

    noReqOnExcept: assert property (@(posedge clk) disable iff (!rstN)
        memExcept |-> !dataReq.req)
        else $error("memory request raised with a misaligned address.");

    // data has priority in the arbiter, so its answer is never late.
    dataRespOnTime: assert property (@(posedge clk) disable iff (!rstN)
        dataReq.req |=> dataResp.rvalid)
        else $error("data response missing one cycle after the request.");

endmodule

// File: fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           fetchEn,
    input  logic [31:0]    fetchStartPc,
    output cpuPkg::memReq  fetchReq,
    input  cpuPkg::memResp fetchResp,
    output logic           fetchValid,
    output logic [31:0]    fetchInstr,
    output logic [31:0]    fetchPc
);
    import cpuPkg::*;

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] reqPc;

    assign pcPlus4 = pc + 32'd4;

    // the word at pc is being answered now, so the request moves on to the next one.
    assign reqPc = fetchResp.rvalid ? pcPlus4 : pc;

    always_comb begin
        fetchReq.req       = fetchEn;
        fetchReq.wordAddr  = reqPc[memAddrBits+1:2];
        fetchReq.byteEn    = 4'b0000;      // fetch never writes.
        fetchReq.writeData = '0;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= fetchStartPc;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= fetchResp.rvalid;
            if (fetchResp.rvalid) begin
                pc <= pcPlus4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchResp.rvalid) begin
            fetchInstr <= fetchResp.readData;
            fetchPc    <= pc;
        end
    end

endmodule

// File: memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic           clk,
    input  logic           rstN,
    input  cpuPkg::memReq  dataReq,
    input  cpuPkg::memReq  fetchReq,
    output cpuPkg::memResp dataResp,
    output cpuPkg::memResp fetchResp,
    output cpuPkg::memReq  memBusReq,
    input  cpuPkg::memResp memBusResp
);

    logic dataGrant;
    logic fetchGrant;
    logic ownerData;
    logic ownerFetch;

    assign dataGrant  = dataReq.req;
    assign fetchGrant = fetchReq.req && !dataReq.req;     // fetch only gets idle cycles.

    assign memBusReq = dataGrant ? dataReq : fetchReq;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ownerData  <= 1'b0;
            ownerFetch <= 1'b0;
        end else begin
            ownerData  <= dataGrant;
            ownerFetch <= fetchGrant;
        end
    end

    always_comb begin
        dataResp.rvalid    = memBusResp.rvalid && ownerData;
        dataResp.readData  = memBusResp.readData;
        fetchResp.rvalid   = memBusResp.rvalid && ownerFetch;
        fetchResp.readData = memBusResp.readData;
    end

    // each memory answer goes to exactly one requester.
    oneOwner: assert property (@(posedge clk) disable iff (!rstN)
        memBusResp.rvalid |-> (dataResp.rvalid != fetchResp.rvalid))
        else $error("memory response not steered to exactly one requester.");

endmodule

// File: unifiedMemory.sv
`timescale 1ns/1ps

module unifiedMemory (
    input  logic           clk,
    input  cpuPkg::memReq  busReq,
    output cpuPkg::memResp busResp
);
    import cpuPkg::*;

    logic [dataWidth-1:0] mem [memWords] = '{default: '0};

    // the read sees the word as it was before this cycle's write.
    always_ff @(posedge clk) begin
        if (busReq.req) begin
            busResp.readData <= mem[busReq.wordAddr];
            for (int lane = 0; lane < 4; lane++) begin
                if (busReq.byteEn[lane]) begin
                    mem[busReq.wordAddr][lane*8 +: 8] <= busReq.writeData[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        busResp.rvalid <= busReq.req;     // every request is answered, writes too.
    end

endmodule

// File: memStageTop.sv
`timescale 1ns/1ps

module memStageTop (
    input  logic                clk,
    input  logic                rstN,
    input  cpuPkg::exeMemBundle exeIn,
    input  logic                memFlush,
    input  logic                fetchEn,
    input  logic [31:0]         fetchStartPc,
    output logic                exeStall,
    output cpuPkg::exeMemBundle stageOut,
    output logic                wbValid,
    output logic [31:0]         wbData,
    output logic [4:0]          wbDst,
    output logic                memExcept,
    output logic                dcacheFlush,
    output logic                fetchValid,
    output logic [31:0]         fetchInstr,
    output logic [31:0]         fetchPc
);
    import cpuPkg::*;

    logic   memWr;
    memReq  dataReq;
    memReq  fetchReq;
    memReq  memBusReq;
    memResp dataResp;
    memResp fetchResp;
    memResp memBusResp;

    assign memWr = !exeStall;

    exeMemReg iExeMemReg (
        .clk         (clk),
        .rstN        (rstN),
        .memWr       (memWr),
        .memFlush    (memFlush),
        .exeIn       (exeIn),
        .stageOut    (stageOut),
        .dcacheFlush (dcacheFlush)
    );

    loadStoreUnit iLoadStoreUnit (
        .clk       (clk),
        .rstN      (rstN),
        .stageIn   (stageOut),
        .dataReq   (dataReq),
        .dataResp  (dataResp),
        .stall     (exeStall),
        .wbValid   (wbValid),
        .wbData    (wbData),
        .wbDst     (wbDst),
        .memExcept (memExcept)
    );

    fetchUnit iFetchUnit (
        .clk          (clk),
        .rstN         (rstN),
        .fetchEn      (fetchEn),
        .fetchStartPc (fetchStartPc),
        .fetchReq     (fetchReq),
        .fetchResp    (fetchResp),
        .fetchValid   (fetchValid),
        .fetchInstr   (fetchInstr),
        .fetchPc      (fetchPc)
    );

    memArbiter iMemArbiter (
        .clk        (clk),
        .rstN       (rstN),
        .dataReq    (dataReq),
        .fetchReq   (fetchReq),
        .dataResp   (dataResp),
        .fetchResp  (fetchResp),
        .memBusReq  (memBusReq),
        .memBusResp (memBusResp)
    );

    unifiedMemory iUnifiedMemory (
        .clk     (clk),
        .busReq  (memBusReq),
        .busResp (memBusResp)
    );

endmodule

// File: tbMemStage.sv
`timescale 1ns/1ps

module tbMemStage;
    import cpuPkg::*;

    localparam int waitLimit = 20;

    logic        clk;
    logic        rstN;
    exeMemBundle exeIn;
    logic        memFlush;
    logic        fetchEn;
    logic [31:0] fetchStartPc;
    logic        exeStall;
    exeMemBundle stageOut;
    logic        wbValid;
    logic [31:0] wbData;
    logic [4:0]  wbDst;
    logic        memExcept;
    logic        dcacheFlush;
    logic        fetchValid;
    logic [31:0] fetchInstr;
    logic [31:0] fetchPc;

    logic [31:0] refMem [memWords];
    logic [31:0] nextFetchPc;
    int          errCount;
    int          checkCount;
    int          fetchCount;
    logic        aborted;

    memStageTop i_dut (
        .clk          (clk),
        .rstN         (rstN),
        .exeIn        (exeIn),
        .memFlush     (memFlush),
        .fetchEn      (fetchEn),
        .fetchStartPc (fetchStartPc),
        .exeStall     (exeStall),
        .stageOut     (stageOut),
        .wbValid      (wbValid),
        .wbData       (wbData),
        .wbDst        (wbDst),
        .memExcept    (memExcept),
        .dcacheFlush  (dcacheFlush),
        .fetchValid   (fetchValid),
        .fetchInstr   (fetchInstr),
        .fetchPc      (fetchPc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic waitStallLow(input string name);
        int n;
        n = 0;
        while (exeStall && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (exeStall) begin
            errCount++;
            aborted = 1'b1;
            $display("timeout in %s because exeStall never dropped", name);
        end
    endtask

    task automatic waitWbValid(input string name);
        int n;
        n = 0;
        while (!wbValid && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!wbValid) begin
            errCount++;
            aborted = 1'b1;
            $display("timeout in %s because wbValid never came", name);
        end
    endtask

    // byte lanes follow the low address bits, as a store to memory does.
    task automatic refStore(input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] kind);
        logic [31:0] word;
        word = refMem[addr[memAddrBits+1:2]];
        case (storeType'(kind[1:0]))
            storeByte: word[addr[1:0]*8 +: 8] = data[7:0];
            storeHalf: word[addr[1]*16 +: 16] = data[15:0];
            storeWord: word = data;
            default:   word = word;
        endcase
        refMem[addr[memAddrBits+1:2]] = word;
    endtask

    function automatic exeMemBundle makeBundle(input logic [15:0] tag,
            input logic [31:0] addr, input logic [31:0] data, input logic [31:0] kind,
            input logic [31:0] dst, input int idx);
        exeMemBundle b;
        b           = '0;
        b.valid     = 1'b1;
        b.aluOut    = addr;
        b.storeData = data;
        b.pc        = 32'h0040_0000 + 32'(idx * 4);
        b.dst       = dst[4:0];
        b.regsWr    = !(tag == "S" || tag == "XS");
        if (tag == "S" || tag == "XS") begin
            b.storeKind = storeType'(kind[1:0]);
        end else if (tag != "A") begin
            b.loadKind = loadType'(kind[2:0]);
        end
        return b;
    endfunction

    // the bundle stays on exeIn until an unstalled edge takes it.
    task automatic issue(input exeMemBundle b, input string name);
        @(posedge clk);
        exeIn <= b;
        @(negedge clk);
        waitStallLow(name);
        @(posedge clk);
        exeIn <= '0;
    endtask

    task automatic runOp(input logic [15:0] tag, input logic [31:0] addr,
            input logic [31:0] data, input logic [31:0] kind, input logic [31:0] dst,
            input logic [31:0] expVal, input int idx);
        exeMemBundle b;
        string       name;
        b    = makeBundle(tag, addr, data, kind, dst, idx);
        name = $sformatf("op %0d", idx);
        case (tag)
            "G": begin
                @(posedge clk);
                fetchEn <= 1'b1;
            end
            "A": begin
                issue(b, name);
                @(negedge clk);
                checkValue({name, " wbValid"}, 1, wbValid);
                checkValue({name, " exeStall"}, 0, exeStall);
                checkValue({name, " wbData"}, expVal, wbData);
                checkValue({name, " wbDst"}, dst, wbDst);
            end
            "S": begin
                issue(b, name);
                @(negedge clk);
                checkValue({name, " exeStall"}, 1, exeStall);
                checkValue({name, " memExcept"}, 0, memExcept);
                waitStallLow(name);
                refStore(addr, data, kind);
            end
            "L": begin
                issue(b, name);
                @(negedge clk);
                checkValue({name, " exeStall"}, 1, exeStall);
                checkValue({name, " memExcept"}, 0, memExcept);
                waitWbValid(name);
                checkValue({name, " wbData"}, expVal, wbData);
                checkValue({name, " wbDst"}, dst, wbDst);
            end
            "XS", "XL": begin
                issue(b, name);
                @(negedge clk);
                checkValue({name, " memExcept"}, 1, memExcept);
                checkValue({name, " wbValid"}, 0, wbValid);
                checkValue({name, " exeStall"}, 0, exeStall);
            end
            "F": begin
                issue(b, name);
                memFlush <= 1'b1;            // held over two edges.
                @(negedge clk);
                checkValue({name, " dcacheFlush before"}, 0, dcacheFlush);
                @(negedge clk);
                checkCount++;
                if (stageOut !== '0) begin
                    errCount++;
                    $display("CHECK FAILED %s stageOut expected %h actual %h",
                             name, exeMemBundle'('0), stageOut);
                end
                checkValue({name, " dcacheFlush"}, 1, dcacheFlush);
                checkValue({name, " wbValid"}, 0, wbValid);
                @(posedge clk);
                memFlush <= 1'b0;
                repeat (2) begin
                    @(negedge clk);
                    checkValue({name, " dcacheFlush after"}, 0, dcacheFlush);
                    checkValue({name, " wbValid after"}, 0, wbValid);
                end
            end
            default: begin
                errCount++;
                $display("trace op %0d has an unknown tag", idx);
            end
        endcase
    endtask

    always @(negedge clk) begin
        if (rstN && fetchValid) begin
            checkValue("fetch pc", nextFetchPc, fetchPc);
            checkValue("fetch instr", refMem[nextFetchPc[memAddrBits+1:2]], fetchInstr);
            nextFetchPc = nextFetchPc + 32'd4;
            fetchCount++;
        end
    end

    initial begin
        int               fd;
        int               code;
        int               opIdx;
        logic             done;
        logic [15:0]      tag;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      kind;
        logic [31:0]      dst;
        logic [31:0]      expVal;
        logic [8*160-1:0] restOfLine;
        rstN         = 1'b0;
        exeIn        = '0;
        memFlush     = 1'b0;
        fetchEn      = 1'b0;
        fetchStartPc = 32'h0000_0008;
        nextFetchPc  = 32'h0000_0008;
        errCount     = 0;
        checkCount   = 0;
        fetchCount   = 0;
        aborted      = 1'b0;
        opIdx        = 0;
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = '0;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        checkValue("reset exeStall", 0, exeStall);
        checkValue("reset wbValid", 0, wbValid);
        checkValue("reset memExcept", 0, memExcept);
        checkValue("reset dcacheFlush", 0, dcacheFlush);
        checkValue("reset fetchValid", 0, fetchValid);
        @(posedge clk);
        rstN <= 1'b1;
        fd = $fopen("memStageTrace.txt", "r");
        if (fd == 0) begin
            errCount++;
            $display("could not open memStageTrace.txt");
        end else begin
            done = 1'b0;
            while (!done && !aborted) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(restOfLine, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h", addr, data, kind, dst, expVal);
                    if (code != 5) begin
                        errCount++;
                        done = 1'b1;
                        $display("trace line after op %0d is malformed", opIdx);
                    end else begin
                        runOp(tag, addr, data, kind, dst, expVal, opIdx);
                        opIdx++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (3) @(negedge clk);
        if (opIdx == 0 || fetchCount < 8) begin
            errCount++;
            $display("too little traffic, %0d ops and %0d fetches seen", opIdx, fetchCount);
        end
        $display("errors %0d in %0d checks over %0d ops and %0d fetches",
                 errCount, checkCount, opIdx, fetchCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: memStageTrace.txt
# tag addr data kind dst expected, numbers in hex
# S store, L load, A alu, XS and XL misaligned, F flushed load, G fetch on
S  00000010 3c0a1234 3 00 00000000
L  00000010 00000000 5 08 3c0a1234
S  00000014 8d2a0004 3 00 00000000
S  00000018 01494020 3 00 00000000
L  00000014 00000000 5 09 8d2a0004
G  00000000 00000000 0 00 00000000
S  00000800 11223344 3 00 00000000
S  00000801 123456a5 1 00 00000000
S  00000802 9876beef 2 00 00000000
L  00000801 00000000 1 0a ffffffa5
L  00000801 00000000 2 0b 000000a5
L  00000802 00000000 3 0c ffffbeef
L  00000802 00000000 4 0d 0000beef
L  00000800 00000000 4 0e 0000a544
L  00000802 00000000 1 0f ffffffef
L  00000800 00000000 5 10 beefa544
XS 00000801 deadbeef 3 00 00000000
XS 00000803 00001234 2 00 00000000
XL 00000806 00000000 5 11 00000000
XL 00000801 00000000 3 12 00000000
L  00000800 00000000 5 13 beefa544
A  00001234 00000000 0 03 00001234
F  00000804 00000000 5 04 00000000
A  cafef00d 00000000 0 05 cafef00d
S  00000803 0000007f 1 00 00000000
L  00000803 00000000 1 14 0000007f
L  00000800 00000000 5 15 7fefa544

// File: src.f
cpuPkg.sv
exeMemReg.sv
loadStoreUnit.sv
fetchUnit.sv
memArbiter.sv
unifiedMemory.sv
memStageTop.sv
tbMemStage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - cpuPkg.sv
  - exeMemReg.sv
  - loadStoreUnit.sv
  - fetchUnit.sv
  - memArbiter.sv
  - unifiedMemory.sv
  - memStageTop.sv
  - target: simulation
    files:
      - tbMemStage.sv
